//--- filelist.f
hdl/gfx_pkg.sv
hdl/render_if.sv
hdl/gfx_fetch.sv
hdl/tile_renderer.sv
hdl/line_buffer.sv
hdl/gfx_top.sv
tb/clock_gen.sv
tb/gfx_tb.sv

//--- hdl/gfx_fetch.sv
`timescale 1ns/100ps

module gfx_fetch import gfx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  xpos_t      line,
    input  logic       hscroll_lock,
    input  xpos_t      hscroll,
    input  xpos_t      vscroll,
    input  logic [2:0] name_base,
    input  logic [5:0] sprattr_base,
    input  logic       sprpat_base,
    input  logic       sprite_tall,
    input  vram_word_t vdata,
    output vram_addr_t vaddr,
    output logic       bank_sel,
    output logic       spr_overflow,
    render_if.fetch    r
);

    fetch_state_t state_r, state_next;
    fetch_state_t ret_state_r, ret_state_next;
    vram_addr_t   vaddr_r, vaddr_next;
    logic [5:0]   col_r, col_next;
    logic [6:0]   spr_idx_r, spr_idx_next;
    logic [3:0]   spr_cnt_r, spr_cnt_next;
    logic         bank_sel_next;
    xpos_t        hscroll_r, hscroll_next;
    xpos_t        vscroll_r, vscroll_next;
    xpos_t        line_r, line_next;
    xpos_t        spr_y_r, spr_y_next;
    xpos_t        render_x_r, render_x_next;
    vram_word_t   pat_lo_r, pat_lo_next;
    logic         is_sprite_r, is_sprite_next;
    logic         hflip_r, hflip_next;
    logic         palette_r, palette_next;
    logic         render_start;
    chunky_row_t  row_chunky;

    ////////////////////////////////
    // Address generation
    ////////////////////////////////
    xpos_t      tline;
    logic [2:0] pat_row;
    vram_addr_t map_addr;
    vram_addr_t pat_addr;
    vram_addr_t spr_addr_y;
    vram_addr_t spr_addr_xn;
    vram_addr_t spr_pat_addr;
    xpos_t      spr_y_byte;
    xpos_t      ydiff;
    logic [3:0] spr_height;
    logic       spr_on_line;
    logic       spr_terminated;
    logic       spr_full;

    // Scrolled tile row, name table entry arrives in vdata
    assign tline    = line_r + vscroll_r;
    assign pat_row  = vdata[10] ? ~tline[2:0] : tline[2:0];
    assign map_addr = {name_base, tline[7:3], col_r[4:0]};
    assign pat_addr = {vdata[8:0], pat_row, 1'b0};

    // Y bytes are packed two per word, X and tile number one entry per word
    assign spr_addr_y  = {sprattr_base, 2'b00, spr_idx_r[5:1]};
    assign spr_addr_xn = {sprattr_base, 1'b1, spr_idx_r[5:0]};
    assign spr_y_byte  = spr_idx_r[0] ? vdata[15:8] : vdata[7:0];

    // Sprite line test, spr_y_r already holds Y + 1
    assign ydiff          = line_r - spr_y_r;
    assign spr_height     = sprite_tall ? 4'd15 : 4'd7;
    assign spr_on_line    = (ydiff <= {4'd0, spr_height});
    assign spr_terminated = (spr_y_r == SPRITE_TERMINATOR + 8'd1);
    assign spr_full       = (spr_cnt_r == 4'(MAX_LINE_SPRITES));

    // Tall sprites take the lower tile bit from the sprite row
    assign spr_pat_addr = {sprpat_base, vdata[15:9], sprite_tall ? ydiff[3] : vdata[8],
                           ydiff[2:0], 1'b0};

    // Bitplanes to chunky, word 0 holds planes 0 and 1, word 1 planes 2 and 3
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            row_chunky[4*i +: 4] = {vdata[8+i], vdata[i], pat_lo_r[8+i], pat_lo_r[i]};
        end
    end

    ////////////////////////////////
    // Fetch FSM
    ////////////////////////////////
    always_comb begin
        state_next     = state_r;
        ret_state_next = ret_state_r;
        vaddr_next     = vaddr_r;
        col_next       = col_r;
        spr_idx_next   = spr_idx_r;
        spr_cnt_next   = spr_cnt_r;
        bank_sel_next  = bank_sel;
        hscroll_next   = hscroll_r;
        vscroll_next   = vscroll_r;
        line_next      = line_r;
        spr_y_next     = spr_y_r;
        render_x_next  = render_x_r;
        pat_lo_next    = pat_lo_r;
        is_sprite_next = is_sprite_r;
        hflip_next     = hflip_r;
        palette_next   = palette_r;
        render_start   = 1'b0;
        spr_overflow   = 1'b0;

        if (start) begin
            if (hscroll_lock && line < HSCROLL_LOCK_LINES)
                hscroll_next = '0;
            else
                hscroll_next = hscroll;
            // Vertical scroll only changes at the top of the frame
            if (line == 8'd0)
                vscroll_next = vscroll;
            line_next      = line;
            bank_sel_next  = !bank_sel;
            col_next       = '0;
            spr_idx_next   = '0;
            spr_cnt_next   = '0;
            is_sprite_next = 1'b0;
            state_next     = MAP_ADDR;
        end else begin
            case (state_r)
                DONE: begin
                end

                MAP_ADDR: begin
                    if (col_r == 6'(NUM_COLUMNS)) begin
                        state_next = SPR_Y;
                    end else begin
                        vaddr_next = map_addr;
                        state_next = MAP_READ;
                    end
                end

                MAP_READ: begin
                    vaddr_next     = pat_addr;
                    hflip_next     = vdata[9];
                    palette_next   = vdata[11];
                    render_x_next  = hscroll_r + {col_r[4:0], 3'b000};
                    col_next       = col_r + 6'd1;
                    ret_state_next = MAP_ADDR;
                    state_next     = PAT_LO;
                end

                SPR_Y: begin
                    if (spr_idx_r == 7'(NUM_SPRITES)) begin
                        state_next = DONE;
                    end else begin
                        vaddr_next = spr_addr_y;
                        state_next = SPR_XN;
                    end
                end

                SPR_XN: begin
                    spr_y_next = spr_y_byte + 8'd1;
                    vaddr_next = spr_addr_xn;
                    state_next = SPR_CHECK;
                end

                SPR_CHECK: begin
                    spr_idx_next   = spr_idx_r + 7'd1;
                    ret_state_next = SPR_Y;
                    if (spr_terminated) begin
                        state_next = DONE;
                    end else if (spr_on_line && spr_full) begin
                        // Ninth sprite on this line
                        spr_overflow = 1'b1;
                        state_next   = DONE;
                    end else if (spr_on_line) begin
                        spr_cnt_next   = spr_cnt_r + 4'd1;
                        vaddr_next     = spr_pat_addr;
                        render_x_next  = vdata[7:0];
                        is_sprite_next = 1'b1;
                        hflip_next     = 1'b0;
                        palette_next   = 1'b1;
                        state_next     = PAT_LO;
                    end else begin
                        state_next = SPR_Y;
                    end
                end

                PAT_LO: begin
                    pat_lo_next = vdata;
                    vaddr_next  = {vaddr_r[12:1], 1'b1};
                    state_next  = PAT_HI;
                end

                PAT_HI: begin
                    // Hold the address so vdata stays valid while waiting
                    if (!r.busy || r.last_pixel) begin
                        render_start = 1'b1;
                        state_next   = ret_state_r;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_r     <= DONE;
            ret_state_r <= DONE;
            vaddr_r     <= '0;
            col_r       <= '0;
            spr_idx_r   <= '0;
            spr_cnt_r   <= '0;
            bank_sel    <= 1'b0;
            hscroll_r   <= '0;
            vscroll_r   <= '0;
        end else begin
            state_r     <= state_next;
            ret_state_r <= ret_state_next;
            vaddr_r     <= vaddr_next;
            col_r       <= col_next;
            spr_idx_r   <= spr_idx_next;
            spr_cnt_r   <= spr_cnt_next;
            bank_sel    <= bank_sel_next;
            hscroll_r   <= hscroll_next;
            vscroll_r   <= vscroll_next;
        end
    end

    always_ff @(posedge clk) begin
        line_r      <= line_next;
        spr_y_r     <= spr_y_next;
        render_x_r  <= render_x_next;
        pat_lo_r    <= pat_lo_next;
        is_sprite_r <= is_sprite_next;
        hflip_r     <= hflip_next;
        palette_r   <= palette_next;
    end

    // VRAM sees the next address, data returns a cycle later
    assign vaddr = vaddr_next;

    assign r.x          = render_x_r;
    assign r.data       = row_chunky;
    assign r.start      = render_start;
    assign r.is_sprite  = is_sprite_r;
    assign r.hflip      = hflip_r;
    assign r.palette    = palette_r;
    assign r.line_begin = start;

endmodule

//--- hdl/gfx_pkg.sv
package gfx_pkg;

    // VRAM is word addressed, 8K x 16
    typedef logic [12:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;

    // Palette select on top, color index below, index 0 is transparent
    typedef logic [4:0] pixel_t;

    // Pixel column, line number and scroll amounts
    typedef logic [7:0] xpos_t;

    // Eight 4-bit pixels, leftmost in the top nibble
    typedef logic [31:0] chunky_row_t;

    typedef enum logic [2:0] {
        DONE,
        MAP_ADDR,
        MAP_READ,
        SPR_Y,
        SPR_XN,
        SPR_CHECK,
        PAT_LO,
        PAT_HI
    } fetch_state_t;

    localparam int NUM_COLUMNS      = 32;
    localparam int NUM_SPRITES      = 64;
    localparam int MAX_LINE_SPRITES = 8;

    // Y value that ends the sprite list
    localparam xpos_t SPRITE_TERMINATOR  = 8'hD0;
    localparam xpos_t HSCROLL_LOCK_LINES = 8'd16;

endpackage

//--- hdl/gfx_top.sv
`timescale 1ns/100ps

module gfx_top import gfx_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // Display registers
    input  logic       hscroll_lock,
    input  xpos_t      hscroll,
    input  xpos_t      vscroll,
    input  logic [2:0] name_base,
    input  logic [5:0] sprattr_base,
    input  logic       sprpat_base,
    input  logic       sprite_tall,

    // Line control
    input  xpos_t      line,
    input  logic       start,

    // VRAM
    output vram_addr_t vaddr,
    input  vram_word_t vdata,

    // Readback
    input  xpos_t      pix_idx,
    output pixel_t     pix,

    output logic       spr_overflow,
    output logic       spr_collision
);

    logic   bank_sel;
    xpos_t  wr_idx;
    pixel_t wr_pixel;
    logic   wr_en;

    render_if rif ();

    gfx_fetch fetch (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .line         (line),
        .hscroll_lock (hscroll_lock),
        .hscroll      (hscroll),
        .vscroll      (vscroll),
        .name_base    (name_base),
        .sprattr_base (sprattr_base),
        .sprpat_base  (sprpat_base),
        .sprite_tall  (sprite_tall),
        .vdata        (vdata),
        .vaddr        (vaddr),
        .bank_sel     (bank_sel),
        .spr_overflow (spr_overflow),
        .r            (rif.fetch)
    );

    tile_renderer renderer (
        .clk           (clk),
        .reset         (reset),
        .r             (rif.render),
        .wr_idx        (wr_idx),
        .wr_pixel      (wr_pixel),
        .wr_en         (wr_en),
        .spr_collision (spr_collision)
    );

    line_buffer linebuf (
        .clk      (clk),
        .bank_sel (bank_sel),
        .wr_idx   (wr_idx),
        .wr_pixel (wr_pixel),
        .wr_en    (wr_en),
        .rd_idx   (pix_idx),
        .rd_pixel (pix)
    );

endmodule

//--- hdl/line_buffer.sv
`timescale 1ns/100ps

module line_buffer import gfx_pkg::*; (
    input  logic   clk,
    input  logic   bank_sel,
    input  xpos_t  wr_idx,
    input  pixel_t wr_pixel,
    input  logic   wr_en,
    input  xpos_t  rd_idx,
    output pixel_t rd_pixel
);

    // Two line banks, one filled while the other is shown
    pixel_t bank_mem [0:1][0:255];

    always_ff @(posedge clk) begin
        if (wr_en)
            bank_mem[bank_sel][wr_idx] <= wr_pixel;
    end

    // Registered read from the idle bank
    always_ff @(posedge clk) begin
        rd_pixel <= bank_mem[!bank_sel][rd_idx];
    end

endmodule

//--- hdl/render_if.sv
`timescale 1ns/100ps

interface render_if import gfx_pkg::*; ();

    // One 8-pixel command, sampled by the renderer in the start cycle
    xpos_t       x;
    chunky_row_t data;
    logic        start;
    logic        is_sprite;
    logic        hflip;
    logic        palette;
    logic        line_begin;

    // Status back to the fetcher
    logic        busy;
    logic        last_pixel;

    modport fetch (output x, data, start, is_sprite, hflip, palette, line_begin,
                   input busy, last_pixel);

    modport render (input x, data, start, is_sprite, hflip, palette, line_begin,
                    output busy, last_pixel);

endinterface

//--- hdl/tile_renderer.sv
`timescale 1ns/100ps

module tile_renderer import gfx_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    render_if.render  r,
    output xpos_t     wr_idx,
    output pixel_t    wr_pixel,
    output logic      wr_en,
    output logic      spr_collision
);

    logic         active_r;
    logic [2:0]   count_r;
    chunky_row_t  shift_r;
    xpos_t        idx_r;
    logic         hflip_r;
    logic         is_sprite_r;
    logic         palette_r;
    logic [255:0] occupied_r;

    logic [3:0]   color;
    logic         opaque;
    logic         taken;

    // Leftmost pixel first, or rightmost first when flipped
    assign color  = hflip_r ? shift_r[3:0] : shift_r[31:28];
    assign opaque = (color != 4'd0);
    assign taken  = occupied_r[idx_r];

    ////////////////////////////////
    // Sequencing
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            active_r <= 1'b0;
            count_r  <= '0;
        end else if (r.start) begin
            active_r <= 1'b1;
            count_r  <= '0;
        end else if (active_r) begin
            count_r <= count_r + 3'd1;
            if (count_r == 3'd7)
                active_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r.start) begin
            shift_r     <= r.data;
            idx_r       <= r.x;
            hflip_r     <= r.hflip;
            is_sprite_r <= r.is_sprite;
            palette_r   <= r.palette;
        end else if (active_r) begin
            shift_r <= hflip_r ? (shift_r >> 4) : (shift_r << 4);
            // Wraps past column 255
            idx_r   <= idx_r + 8'd1;
        end
    end

    ////////////////////////////////
    // Sprite occupancy
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (r.line_begin)
            occupied_r <= '0;
        else if (active_r && is_sprite_r && opaque)
            occupied_r[idx_r] <= 1'b1;
    end

    assign r.busy       = active_r;
    assign r.last_pixel = active_r && (count_r == 3'd7);

    // First sprite in the table keeps the pixel
    assign wr_idx        = idx_r;
    assign wr_pixel      = {palette_r, color};
    assign wr_en         = active_r && (!is_sprite_r || (opaque && !taken));
    assign spr_collision = active_r && is_sprite_r && opaque && taken;

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the gfx_top testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module gfx_tb -f filelist.f \
    --Mdir "$BUILD_DIR" -o gfx_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/gfx_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- tb/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- tb/gfx_tb.sv
`timescale 1ns/100ps

module gfx_tb import gfx_pkg::*; ();

    localparam int LINE_CYCLES = 700;
    localparam int NUM_LINES   = 20;
    localparam int MAX_CYCLES  = LINE_CYCLES * NUM_LINES + 200;

    logic       clk;
    logic       reset;
    logic       hscroll_lock;
    xpos_t      hscroll;
    xpos_t      vscroll;
    logic [2:0] name_base;
    logic [5:0] sprattr_base;
    logic       sprpat_base;
    logic       sprite_tall;
    xpos_t      line;
    logic       start;
    vram_addr_t vaddr;
    vram_word_t vdata;
    xpos_t      pix_idx;
    pixel_t     pix;
    logic       spr_overflow;
    logic       spr_collision;

    vram_word_t vram [0:8191];
    pixel_t     expected [0:255];
    int         exp_overflow;
    int         exp_collision;
    int         last_collisions;
    xpos_t      vscroll_latched;

    int cycles = 0;
    int overflow_count = 0;
    int collision_count = 0;
    int pixel_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;

    clock_gen clkgen (
        .clk   (clk),
        .reset (reset)
    );

    gfx_top uut (
        .clk           (clk),
        .reset         (reset),
        .hscroll_lock  (hscroll_lock),
        .hscroll       (hscroll),
        .vscroll       (vscroll),
        .name_base     (name_base),
        .sprattr_base  (sprattr_base),
        .sprpat_base   (sprpat_base),
        .sprite_tall   (sprite_tall),
        .line          (line),
        .start         (start),
        .vaddr         (vaddr),
        .vdata         (vdata),
        .pix_idx       (pix_idx),
        .pix           (pix),
        .spr_overflow  (spr_overflow),
        .spr_collision (spr_collision)
    );

    // Synchronous VRAM, data one cycle after the address
    always @(posedge clk) begin
        vdata <= vram[vaddr];
    end

    // Flag pulses counted mid cycle
    always @(negedge clk) begin
        if (spr_overflow)
            overflow_count++;
        if (spr_collision)
            collision_count++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic compare_pixel(input xpos_t idx, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("[ERROR] pix at index 0x%02h expected 0x%02h got 0x%02h", idx, exp, got);
            pixel_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s pulses expected 0x%0h got 0x%0h", name, exp, got);
            flag_errors++;
        end
    endtask

    task automatic compare_addr(input vram_addr_t got, input vram_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] vaddr expected 0x%04h got 0x%04h", exp, got);
            other_errors++;
        end
    endtask

    //////////////////////////////
    // VRAM setup
    //////////////////////////////
    task automatic fill_vram_random();
        for (int a = 0; a < 8192; a++)
            vram[a] = 16'($urandom);
    endtask

    task automatic set_sprite_y(input int i, input xpos_t y);
        vram_addr_t a;

        // Two Y bytes per word, odd entries in the high byte
        a = {sprattr_base, 2'b00, 5'(i / 2)};
        if (i % 2 == 1)
            vram[a][15:8] = y;
        else
            vram[a][7:0] = y;
    endtask

    task automatic set_sprite(input int i, input xpos_t y, input xpos_t x,
                              input logic [7:0] tile);
        set_sprite_y(i, y);
        vram[{sprattr_base, 1'b1, 6'(i)}] = {tile, x};
        // Both tiles of the pair, leftmost and rightmost pixels transparent
        for (int k = 0; k < 32; k++)
            vram[{sprpat_base, tile[7:1], 5'(k)}] = 16'($urandom) & 16'h7E7E;
    endtask

    task automatic end_sprite_list(input int i);
        set_sprite_y(i, SPRITE_TERMINATOR);
    endtask

    //////////////////////////////
    // Reference line model
    //////////////////////////////
    task automatic build_reference(input xpos_t ln);
        xpos_t        hs;
        xpos_t        tline;
        xpos_t        x;
        xpos_t        y_byte;
        xpos_t        ydiff;
        vram_word_t   entry;
        vram_word_t   w0;
        vram_word_t   w1;
        vram_addr_t   pat;
        logic [2:0]   row;
        logic [3:0]   color;
        logic [255:0] taken;
        int           height;
        int           drawn;
        int           b;

        hs     = (hscroll_lock && ln < HSCROLL_LOCK_LINES) ? 8'd0 : hscroll;
        tline  = ln + vscroll_latched;
        taken  = '0;
        drawn  = 0;
        height = sprite_tall ? 16 : 8;
        exp_overflow  = 0;
        exp_collision = 0;

        // Background tiles
        for (int col = 0; col < NUM_COLUMNS; col++) begin
            entry = vram[{name_base, tline[7:3], 5'(col)}];
            row   = entry[10] ? 3'd7 - tline[2:0] : tline[2:0];
            pat   = {entry[8:0], row, 1'b0};
            w0    = vram[pat];
            w1    = vram[pat + 13'd1];
            for (int p = 0; p < 8; p++) begin
                b     = 7 - p;
                color = {w1[8 + b], w1[b], w0[8 + b], w0[b]};
                x     = hs + 8'(8 * col) + 8'(entry[9] ? 7 - p : p);
                expected[x] = {entry[11], color};
            end
        end

        // Sprites in table order
        for (int i = 0; i < NUM_SPRITES; i++) begin
            entry  = vram[{sprattr_base, 2'b00, 5'(i / 2)}];
            y_byte = (i % 2 == 1) ? entry[15:8] : entry[7:0];
            if (y_byte == SPRITE_TERMINATOR)
                break;
            ydiff = ln - (y_byte + 8'd1);
            if (int'(ydiff) < height) begin
                if (drawn == MAX_LINE_SPRITES) begin
                    exp_overflow = 1;
                    break;
                end
                drawn++;
                entry = vram[{sprattr_base, 1'b1, 6'(i)}];
                pat   = {sprpat_base, entry[15:9], sprite_tall ? ydiff[3] : entry[8],
                         ydiff[2:0], 1'b0};
                w0    = vram[pat];
                w1    = vram[pat + 13'd1];
                for (int p = 0; p < 8; p++) begin
                    b     = 7 - p;
                    color = {w1[8 + b], w1[b], w0[8 + b], w0[b]};
                    x     = entry[7:0] + 8'(p);
                    if (color != 4'd0) begin
                        if (taken[x]) begin
                            exp_collision++;
                        end else begin
                            expected[x] = {1'b1, color};
                            taken[x]    = 1'b1;
                        end
                    end
                end
            end
        end
    endtask

    //////////////////////////////
    // Line sequencing
    //////////////////////////////
    task automatic pulse_start(input xpos_t ln);
        line  = ln;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic render_and_check(input xpos_t ln);
        int ovf_base;
        int col_base;

        if (ln == 8'd0)
            vscroll_latched = vscroll;
        build_reference(ln);
        ovf_base = overflow_count;
        col_base = collision_count;
        pulse_start(ln);
        repeat (LINE_CYCLES - 1) @(posedge clk);
        #1;
        last_collisions = collision_count - col_base;
        compare_flag("spr_overflow", overflow_count - ovf_base, exp_overflow);
        compare_flag("spr_collision", last_collisions, exp_collision);

        // Next line swaps banks, the finished line is read back meanwhile
        pulse_start(ln + 8'd1);
        for (int i = 0; i < 256; i++) begin
            pix_idx = 8'(i);
            @(posedge clk);
            #1;
            compare_pixel(8'(i), pix, expected[i]);
        end
        repeat (LINE_CYCLES - 1 - 256) @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_idle();
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            #1;
            compare_addr(vaddr, 13'd0);
        end
        compare_flag("spr_overflow", overflow_count, 0);
        compare_flag("spr_collision", collision_count, 0);
    endtask

    task automatic test_background();
        end_sprite_list(0);
        render_and_check(8'd0);
        render_and_check(8'd77);
    endtask

    task automatic test_scroll();
        hscroll = 8'($urandom);
        vscroll = 8'($urandom);
        render_and_check(8'd0);
        // Vertical scroll holds its line 0 value
        vscroll = vscroll + 8'd37;
        hscroll = 8'($urandom);
        render_and_check(8'd100);
        hscroll_lock = 1'b1;
        render_and_check(8'd5);
        render_and_check(8'd20);
        hscroll_lock = 1'b0;
    endtask

    task automatic test_sprites();
        for (int tall = 0; tall < 2; tall++) begin
            sprite_tall = tall[0];
            set_sprite(0, 8'd45, 8'd20, 8'h10);
            // Only reaches line 50 when 16 rows tall
            set_sprite(1, 8'd38, 8'd60, 8'h22);
            set_sprite(2, 8'd49, 8'd252, 8'h34);
            end_sprite_list(3);
            set_sprite(4, 8'd47, 8'd120, 8'h46);
            render_and_check(8'd50);
        end
        sprite_tall = 1'b0;
    endtask

    task automatic test_overflow();
        for (int i = 0; i < 9; i++)
            set_sprite(i, 8'd57, 8'(28 * i), 8'h50 + 8'(2 * i));
        end_sprite_list(9);
        render_and_check(8'd60);
    endtask

    task automatic test_collision();
        set_sprite(0, 8'd65, 8'd100, 8'h60);
        set_sprite(1, 8'd65, 8'd103, 8'h62);
        end_sprite_list(2);
        render_and_check(8'd70);
        if (last_collisions == 0) begin
            $display("Overlapping sprites on line 70 gave no collision pulse");
            other_errors++;
        end
    endtask

    initial begin
        void'($urandom(41465));
        hscroll_lock    = 1'b0;
        hscroll         = '0;
        vscroll         = '0;
        name_base       = 3'd2;
        sprattr_base    = 6'h3F;
        sprpat_base     = 1'b1;
        sprite_tall     = 1'b0;
        line            = '0;
        start           = 1'b0;
        pix_idx         = '0;
        vscroll_latched = '0;
        last_collisions = 0;
        fill_vram_random();

        @(posedge clk);
        while (reset)
            @(posedge clk);
        #1;

        test_idle();
        test_background();
        test_scroll();
        test_sprites();
        test_overflow();
        test_collision();

        $display("Pixel errors %0d, flag errors %0d, other errors %0d",
                 pixel_errors, flag_errors, other_errors);
        if (pixel_errors + flag_errors + other_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
